//--- dv/cpuGolden.mem
// Hex words. First the test count, then per test: cycle budget, program length,
// program words, expected store count, then store address and data pairs in order
04
// ALU register and immediate forms, results stored from address 0
28 19
06400093 FF900113 002081B3 40208233 0020F2B3 0020E333 0020C3B3
00112433 0020A4B3 F3808513 0F017593 8000E613 7FF0C693
00302023 00402223 00502423 00602623 00702823 00802A23
00902C23 00A02E23 02B02023 02C02223 02D02423 00000063
0B
00000000 0000005D 00000004 0000006B
00000008 00000060 0000000C FFFFFFFD
00000010 FFFFFF9D 00000014 00000001
00000018 00000000 0000001C FFFFFF9C
00000020 000000F0 00000024 FFFFF864
00000028 0000079B
// Writes to x0 are dropped
14 06
03700013 00002023 06400093 00108033 00002223 00000063
02
00000000 00000000 00000004 00000000
// Store, load back, store again, then store and load of one word
1E 0D
12300093 FFF00113 04102023 08202023 04002183 08002203 0C302423
0C402623 55A00293 04502023 04002303 04602423 00000063
06
00000040 00000123 00000080 FFFFFFFF 000000C8 00000123
000000CC FFFFFFFF 00000040 0000055A 00000048 0000055A
// Counting loop with bne, then beq and bne taken and not taken
28 0C
00300093 00000113 00110113 00202023 FE111CE3 00110463
00102223 00010463 00102423 00211463 00202623 00000063
05
00000000 00000001 00000000 00000002 00000000 00000003
00000008 00000003 0000000C 00000003

//--- dv/singleCpuTb.sv
`timescale 1ns/100ps

module singleCpuTb
    import rvIsaPkg::*;
();

    localparam int              CLK_PERIOD   = 100;
    localparam int              RESET_CYCLES = 10;
    localparam int              GOLDEN_WORDS = 256;
    localparam string           GOLDEN_FILE  = "dv/cpuGolden.mem";
    localparam logic [XLEN-1:0] NOP          = 32'h00000013; // addi x0,x0,0
    localparam logic [XLEN-1:0] HALT         = 32'h00000063; // beq x0,x0,0
    localparam logic [XLEN-1:0] RESET_STORE  = 32'h00002023; // sw x0,0(x0) held off by reset
    localparam int              RAND_PAIRS   = 8;
    localparam int              RAND_BUDGET  = 2 * RAND_PAIRS + 10;
    localparam logic [31:0]     SEED         = 32'h8da448ef;

    logic            CLK;
    logic            rst;
    logic [XLEN-1:0] inst;
    logic [XLEN-1:0] pc;
    logic            storeValid;
    logic [XLEN-1:0] storeAddr;
    logic [XLEN-1:0] storeData;

    logic [XLEN-1:0] golden [GOLDEN_WORDS];
    logic [XLEN-1:0] prog [$];    // Program of the current test
    logic [XLEN-1:0] expAddr [$];
    logic [XLEN-1:0] expData [$];
    int              budget;
    int              errorCount;
    int              passCount;
    int              failCount;
    logic [31:0]     rngState;
    logic            limitReady;
    longint          limitCycles;

    singleCpu i_dut (
        .CLK(CLK), .rst(rst), .inst(inst), .pc(pc),
        .storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Instruction memory model, no-op past the end
    function automatic logic [XLEN-1:0] fetchWord(input logic [XLEN-1:0] addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < prog.size()) begin
            return prog[idx];
        end
        return NOP;
    endfunction

    // Sum of all budgets plus reset time
    function automatic longint watchdogCycles(input int numTests);
        longint total;
        int     pos;
        int     cnt;
        total = 0;
        pos   = 1;
        for (int t = 0; t < numTests; t++) begin
            total += golden[pos] + RESET_CYCLES + 1;
            pos   += 2 + golden[pos + 1];
            cnt    = golden[pos];
            pos   += 1 + 2 * cnt;
        end
        total += RAND_BUDGET + RESET_CYCLES + 1;
        return total;
    endfunction

    task automatic loadGoldenTest(inout int pos);
        int len;
        int cnt;
        prog.delete();
        expAddr.delete();
        expData.delete();
        budget = golden[pos];
        len    = golden[pos + 1];
        pos   += 2;
        for (int k = 0; k < len; k++) begin
            prog.push_back(golden[pos + k]);
        end
        pos += len;
        cnt  = golden[pos];
        pos++;
        for (int k = 0; k < cnt; k++) begin
            expAddr.push_back(golden[pos]);
            expData.push_back(golden[pos + 1]);
            pos += 2;
        end
    endtask

    // addi x5 chain, each sum stored to its own word
    task automatic buildRandomTest();
        logic [11:0]     immVal;
        logic [11:0]     offset;
        logic [XLEN-1:0] sum;
        prog.delete();
        expAddr.delete();
        expData.delete();
        sum = '0;
        for (int k = 0; k < RAND_PAIRS; k++) begin
            rngState = xorshift32(rngState);
            immVal   = rngState[11:0];
            offset   = 12'h100 + 12'(k * 4);
            sum      = sum + {{(XLEN - 12){immVal[11]}}, immVal};
            prog.push_back({immVal, 5'd5, F3_ADD_SUB, 5'd5, OP_IMM});
            prog.push_back({offset[11:5], 5'd5, 5'd0, F3_WORD, offset[4:0], STORE});
            expAddr.push_back({20'h0, offset});
            expData.push_back(sum);
        end
        prog.push_back(HALT);
        budget = RAND_BUDGET;
    endtask

    task automatic applyReset();
        rst  = 1'b1;
        inst = RESET_STORE;
        repeat (RESET_CYCLES) begin
            @(posedge CLK);
            #1;
            if (pc !== '0) begin
                $display("MISMATCH pc in reset expected %08h actual %08h", 32'h0, pc);
                errorCount++;
            end
            if (storeValid !== 1'b0) begin
                $display("MISMATCH storeValid in reset expected 0 actual %h", storeValid);
                errorCount++;
            end
        end
        rst = 1'b0;
    endtask

    task automatic checkStore(input int idx);
        if (idx >= expAddr.size()) begin
            $display("Unexpected extra store to %08h with data %08h", storeAddr, storeData);
            errorCount++;
        end else begin
            if (storeAddr !== expAddr[idx]) begin
                $display("MISMATCH storeAddr #%0d expected %08h actual %08h",
                         idx, expAddr[idx], storeAddr);
                errorCount++;
            end
            if (storeData !== expData[idx]) begin
                $display("MISMATCH storeData #%0d expected %08h actual %08h",
                         idx, expData[idx], storeData);
                errorCount++;
            end
        end
    endtask

    task automatic runTest(input string name);
        int              cycle;
        int              stores;
        int              stable;
        int              errorsBefore;
        logic [XLEN-1:0] prevPc;
        errorsBefore = errorCount;
        cycle        = 0;
        stores       = 0;
        stable       = 0;
        prevPc       = '0;
        applyReset();
        while (stable < 2 && cycle < budget) begin
            inst = fetchWord(pc);
            @(negedge CLK);
            if ((cycle == 0 && pc !== 32'h0) || (cycle == 1 && pc !== 32'h4)) begin
                $display("MISMATCH pc cycle %0d expected %08h actual %08h",
                         cycle, 32'(cycle * 4), pc);
                errorCount++;
            end
            if (cycle > 0 && pc === prevPc) begin
                stable++;            // Halt loop holds pc
            end else begin
                stable = 0;
            end
            if (storeValid === 1'b1) begin
                checkStore(stores);
                stores++;
            end
            prevPc = pc;
            @(posedge CLK);
            #1;
            cycle++;
        end
        if (stable < 2) begin
            $display("Program did not reach its halt loop within %0d cycles", budget);
            errorCount++;
        end
        if (stores < expAddr.size()) begin
            $display("Missing stores, saw %0d of %0d", stores, expAddr.size());
            errorCount++;
        end
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("Test %s passed, %0d stores in %0d cycles", name, stores, cycle);
        end else begin
            failCount++;
            $display("Test %s failed with %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    initial begin
        wait (limitReady);
        #(limitCycles * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, tests still running", limitCycles);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int pos;
        int numTests;
        rst        = 1'b1;
        inst       = NOP;
        errorCount = 0;
        passCount  = 0;
        failCount  = 0;
        rngState   = SEED;
        limitReady = 1'b0;
        $readmemh(GOLDEN_FILE, golden);
        if (golden[0] === 'x) begin
            $display("Could not read golden data from %s", GOLDEN_FILE);
            failCount++;
            numTests = 0;
        end else begin
            numTests = golden[0];
        end
        limitCycles = watchdogCycles(numTests);
        limitReady  = 1'b1;

        pos = 1;
        for (int t = 0; t < numTests; t++) begin
            loadGoldenTest(pos);
            runTest($sformatf("%0d golden", t + 1));
        end
        buildRandomTest();
        runTest($sformatf("%0d random addi", numTests + 1));

        $display("Tests finished: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
hdl/rvIsaPkg.sv
hdl/cpuCtrlPkg.sv
hdl/fetchUnit.sv
hdl/instDecoder.sv
hdl/regFile.sv
hdl/executeUnit.sv
hdl/dataMem.sv
hdl/singleCpu.sv
dv/singleCpuTb.sv

//--- hdl/cpuCtrlPkg.sv
package cpuCtrlPkg;

    // Data memory geometry
    localparam int DMEM_WORDS  = 64;
    localparam int DMEM_ADDR_W = 6;  // Word index, byte address bits 7:2

    // ALU function select, classic control codes
    typedef enum logic [3:0] {
        ALU_AND = 4'b0000,
        ALU_OR  = 4'b0001,
        ALU_ADD = 4'b0010,
        ALU_XOR = 4'b0011,
        ALU_SUB = 4'b0110,
        ALU_SLT = 4'b0111
    } aluOpT;

    // One instruction's worth of datapath control
    typedef struct packed {
        aluOpT aluOp;
        logic  aluSrcImm; // Operand B from immediate
        logic  regWrite;
        logic  memWrite;
        logic  memToReg;  // Write back load data
        logic  branch;
        logic  branchNe;  // Take on not-equal
        logic  illegal;
    } ctrlWordT;

    // Safe no-op word used for unknown encodings
    localparam ctrlWordT CTRL_ILLEGAL = '{
        aluOp:     ALU_ADD,
        aluSrcImm: 1'b0,
        regWrite:  1'b0,
        memWrite:  1'b0,
        memToReg:  1'b0,
        branch:    1'b0,
        branchNe:  1'b0,
        illegal:   1'b1
    };

endpackage

//--- hdl/dataMem.sv
`timescale 1ns/100ps

module dataMem
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  logic            CLK,
    input  logic            rst,
    input  logic            memWrite,
    input  logic [XLEN-1:0] addr,
    input  logic [XLEN-1:0] wrData,
    output logic [XLEN-1:0] loadData,
    output logic            storeValid,
    output logic [XLEN-1:0] storeAddr,
    output logic [XLEN-1:0] storeData
);

    logic [XLEN-1:0]        mem [DMEM_WORDS];
    logic [DMEM_ADDR_W-1:0] wordIdx;
    logic                   storeEn;

    // Word aligned, upper address bits ignored
    assign wordIdx = addr[DMEM_ADDR_W+1:2];

    // Held in reset, so nothing may commit
    assign storeEn = memWrite && !rst;

    always_ff @(posedge CLK) begin
        if (storeEn) begin
            mem[wordIdx] <= wrData;
        end
    end

    assign loadData = mem[wordIdx];   // Combinational load

    // Store strobe during the execute cycle
    assign storeValid = storeEn;
    assign storeAddr  = addr;
    assign storeData  = wrData;

endmodule

//--- hdl/executeUnit.sv
`timescale 1ns/100ps

module executeUnit
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  instWordT              inst,
    input  ctrlWordT              ctrl,
    input  logic [XLEN-1:0]       imm,
    input  logic [XLEN-1:0]       rdData1,
    input  logic [XLEN-1:0]       rdData2,
    input  logic [XLEN-1:0]       loadData,
    output logic [XLEN-1:0]       aluResult,
    output logic                  wbEn,
    output logic [REG_ADDR_W-1:0] wbAddr,
    output logic [XLEN-1:0]       wbData,
    output logic                  takeBranch
);

    logic [XLEN-1:0] opA;
    logic [XLEN-1:0] opB;
    logic            lessThan;
    logic            operandsEq;

    assign opA = rdData1;

    // Immediate replaces rs2 for I and S formats
    always_comb begin
        if (ctrl.aluSrcImm) begin
            opB = imm;
        end else begin
            opB = rdData2;
        end
    end

    assign lessThan = $signed(opA) < $signed(opB);

    always_comb begin
        case (ctrl.aluOp)
            ALU_ADD: aluResult = opA + opB;   // Also the lw/sw address
            ALU_SUB: aluResult = opA - opB;
            ALU_AND: aluResult = opA & opB;
            ALU_OR:  aluResult = opA | opB;
            ALU_XOR: aluResult = opA ^ opB;
            ALU_SLT: aluResult = {{(XLEN-1){1'b0}}, lessThan};
            default: aluResult = '0;
        endcase
    end

    // Branch compare
    assign operandsEq = (opA == opB);

    always_comb begin
        takeBranch = 1'b0;
        if (ctrl.branch && !ctrl.illegal) begin
            takeBranch = operandsEq ^ ctrl.branchNe;
        end
    end

    // Write back
    assign wbEn   = ctrl.regWrite && !ctrl.illegal;
    assign wbAddr = inst.r.rd;

    always_comb begin
        if (ctrl.memToReg) begin
            wbData = loadData;
        end else begin
            wbData = aluResult;
        end
    end

endmodule

//--- hdl/fetchUnit.sv
`timescale 1ns/100ps

module fetchUnit
    import rvIsaPkg::*;
(
    input  logic            CLK,
    input  logic            rst,
    input  logic            takeBranch,
    input  logic [XLEN-1:0] branchOffset,
    output logic [XLEN-1:0] pc
);

    logic [XLEN-1:0] pcPlus4;
    logic [XLEN-1:0] branchTarget;
    logic [XLEN-1:0] nextPc;

    // Sequential fall-through
    assign pcPlus4 = pc + XLEN'(4);

    // Offset is already a byte offset with bit 0 clear
    assign branchTarget = pc + branchOffset;

    always_comb begin
        if (takeBranch) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    // Program counter
    always_ff @(posedge CLK) begin
        if (rst) begin
            pc <= '0;             // Fetch starts at address zero
        end else begin
            pc <= nextPc;
        end
    end

endmodule

//--- hdl/instDecoder.sv
`timescale 1ns/100ps

module instDecoder
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  instWordT        inst,
    output ctrlWordT        ctrl,
    output logic [XLEN-1:0] imm
);

    logic [XLEN-1:0] iImm;
    logic [XLEN-1:0] sImm;
    logic [XLEN-1:0] bImm;
    logic            rFunct7Ok;

    // Sign-extended immediates, one per format view
    assign iImm = {{(XLEN-12){inst.i.imm[11]}}, inst.i.imm};
    assign sImm = {{(XLEN-12){inst.s.immHi[6]}}, inst.s.immHi, inst.s.immLo};
    assign bImm = {{(XLEN-13){inst.b.immSign}}, inst.b.immSign, inst.b.imm11,
                   inst.b.immMid, inst.b.immLow, 1'b0};

    // Only sub may use the alternate funct7
    assign rFunct7Ok = (inst.r.funct7 == F7_BASE) ||
                       (inst.r.funct7 == F7_ALT && inst.r.funct3 == F3_ADD_SUB);

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = ALU_ADD;
        imm        = '0;

        case (inst.r.opcode)
            OP: begin
                ctrl.regWrite = 1'b1;
                case (inst.r.funct3)
                    F3_ADD_SUB: ctrl.aluOp = inst.r.funct7[5] ? ALU_SUB : ALU_ADD;
                    F3_AND:     ctrl.aluOp = ALU_AND;
                    F3_OR:      ctrl.aluOp = ALU_OR;
                    F3_XOR:     ctrl.aluOp = ALU_XOR;
                    F3_SLT:     ctrl.aluOp = ALU_SLT;
                    default:    ctrl.illegal = 1'b1;
                endcase
                if (!rFunct7Ok) begin
                    ctrl.illegal = 1'b1;
                end
            end
            OP_IMM: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                imm            = iImm;
                case (inst.i.funct3)
                    F3_ADD_SUB: ctrl.aluOp = ALU_ADD;
                    F3_AND:     ctrl.aluOp = ALU_AND;
                    F3_OR:      ctrl.aluOp = ALU_OR;
                    F3_XOR:     ctrl.aluOp = ALU_XOR;
                    default:    ctrl.illegal = 1'b1; // slti and shifts not kept
                endcase
            end
            LOAD: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.memToReg  = 1'b1;
                imm            = iImm;
                if (inst.i.funct3 != F3_WORD) begin
                    ctrl.illegal = 1'b1;
                end
            end
            STORE: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                imm            = sImm;
                if (inst.s.funct3 != F3_WORD) begin
                    ctrl.illegal = 1'b1;
                end
            end
            BRANCH: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = ALU_SUB;
                imm         = bImm;
                case (inst.b.funct3)
                    F3_BEQ:  ctrl.branchNe = 1'b0;
                    F3_BNE:  ctrl.branchNe = 1'b1;
                    default: ctrl.illegal  = 1'b1;
                endcase
            end
            default: ctrl.illegal = 1'b1;
        endcase

        // Unknown encoding becomes a no-op
        if (ctrl.illegal) begin
            ctrl = CTRL_ILLEGAL;
        end
    end

endmodule

//--- hdl/regFile.sv
`timescale 1ns/100ps

module regFile
    import rvIsaPkg::*;
(
    input  logic                  CLK,
    input  logic                  rst,
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2,
    input  logic                  wrEn,
    input  logic [REG_ADDR_W-1:0] wrAddr,
    input  logic [XLEN-1:0]       wrData,
    output logic [XLEN-1:0]       rdData1,
    output logic [XLEN-1:0]       rdData2
);

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    // x0 has no storage
    logic [XLEN-1:0] regs [1:NUM_REGS-1];

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;   // Writes to x0 fall away
        end
    end

    // Combinational reads see the value before this cycle's write
    always_comb begin
        if (rs1 == '0) begin
            rdData1 = '0;
        end else begin
            rdData1 = regs[rs1];
        end
    end

    always_comb begin
        if (rs2 == '0) begin
            rdData2 = '0;
        end else begin
            rdData2 = regs[rs2];
        end
    end

endmodule

//--- hdl/rvIsaPkg.sv
package rvIsaPkg;

    localparam int XLEN       = 32; // Data word width
    localparam int REG_ADDR_W = 5;  // Register index width

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcodeT;

    localparam logic [2:0] F3_ADD_SUB = 3'b000; // add, sub, addi
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100; // xor, xori
    localparam logic [2:0] F3_OR      = 3'b110; // or, ori
    localparam logic [2:0] F3_AND     = 3'b111; // and, andi
    localparam logic [2:0] F3_WORD    = 3'b010; // lw and sw
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // Selects sub

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        opcodeT                opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        opcodeT                opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0]            immHi; // imm[11:5]
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            immLo; // imm[4:0]
        opcodeT                opcode;
    } sTypeT;

    // Branch offsets are scrambled and always even
    typedef struct packed {
        logic                  immSign; // imm[12]
        logic [5:0]            immMid;  // imm[10:5]
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            immLow;  // imm[4:1]
        logic                  imm11;
        opcodeT                opcode;
    } bTypeT;

    typedef union packed {
        rTypeT            r;
        iTypeT            i;
        sTypeT            s;
        bTypeT            b;
        logic [XLEN-1:0]  raw;
    } instWordT;

endpackage

//--- hdl/singleCpu.sv
`timescale 1ns/100ps

module singleCpu
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  logic            CLK,
    input  logic            rst,
    input  logic [XLEN-1:0] inst,
    output logic [XLEN-1:0] pc,
    output logic            storeValid,
    output logic [XLEN-1:0] storeAddr,
    output logic [XLEN-1:0] storeData
);

    instWordT              instWord;
    ctrlWordT              ctrl;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       rdData1;
    logic [XLEN-1:0]       rdData2;
    logic [XLEN-1:0]       loadData;
    logic [XLEN-1:0]       aluResult;
    logic                  wbEn;
    logic [REG_ADDR_W-1:0] wbAddr;
    logic [XLEN-1:0]       wbData;
    logic                  takeBranch;

    assign instWord.raw = inst;   // One fetched word, several views

    fetchUnit i_fetch (
        .CLK(CLK), .rst(rst), .takeBranch(takeBranch), .branchOffset(imm), .pc(pc)
    );

    instDecoder i_decoder (.inst(instWord), .ctrl(ctrl), .imm(imm));

    // Register indices come straight from the R layout
    regFile i_regFile (
        .CLK(CLK), .rst(rst), .rs1(instWord.r.rs1), .rs2(instWord.r.rs2),
        .wrEn(wbEn), .wrAddr(wbAddr), .wrData(wbData),
        .rdData1(rdData1), .rdData2(rdData2)
    );

    executeUnit i_execute (
        .inst(instWord), .ctrl(ctrl), .imm(imm), .rdData1(rdData1), .rdData2(rdData2),
        .loadData(loadData), .aluResult(aluResult), .wbEn(wbEn), .wbAddr(wbAddr),
        .wbData(wbData), .takeBranch(takeBranch)
    );

    dataMem i_dataMem (
        .CLK(CLK), .rst(rst), .memWrite(ctrl.memWrite), .addr(aluResult),
        .wrData(rdData2), .loadData(loadData), .storeValid(storeValid),
        .storeAddr(storeAddr), .storeData(storeData)
    );

endmodule
